// File: tb.f
verilog/am_lock_pkg.sv
verilog/am_pattern_matcher.sv
verilog/am_block_counter.sv
verilog/am_lock_fsm.sv
verilog/am_lock_top.sv
tests/tb_am_lock.sv

// File: tests/tb_am_lock.sv
`timescale 1ns/1ps

module tb_am_lock;

        // Each accepted block carries a tag that names the lane of a good marker
        // Fillers and corrupted markers get the negative tags
        localparam int TAG_FILLER = -1;
        localparam int TAG_BAD    = -2;
        localparam int TIMEOUT    = 40;

        logic                       tb_clock = 1'b0;
        logic                       i_rst_n;
        logic                       i_enable;
        logic                       i_valid;
        logic                       i_block_lock;
        am_lock_pkg::coded_block_t  i_data;
        am_lock_pkg::inv_am_thr_t   i_invalid_am_thr;
        am_lock_pkg::val_am_thr_t   i_valid_am_thr;
        am_lock_pkg::coded_block_t  o_data;
        logic                       o_valid;
        am_lock_pkg::lane_id_t      o_lane_id;
        am_lock_pkg::error_count_t  o_error_counter;
        logic                       o_am_lock;
        logic                       o_resync;
        logic                       o_start_of_lane;

        logic [31:0]                lfsr;
        int                         cycle = 0;
        int                         drive_tag;
        int                         expect_lane;
        int                         exp_err;
        int                         mon_tag;
        int                         n_resync = 0;

        // Blocks still in flight, with the cycle they were driven in
        am_lock_pkg::coded_block_t  exp_data[$];
        int                         exp_cycle[$];
        int                         exp_tag[$];

        // Status seen together with the most recent marker slot block on the output
        logic                       snap_lock;
        logic                       snap_sol;
        logic                       snap_resync;
        am_lock_pkg::lane_id_t      snap_lane;
        am_lock_pkg::error_count_t  snap_err;

        am_lock_top dut
        (
                .tb_clock               (tb_clock),
                .i_rst_n                (i_rst_n),
                .i_enable               (i_enable),
                .i_valid                (i_valid),
                .i_block_lock           (i_block_lock),
                .i_data                 (i_data),
                .i_invalid_am_thr       (i_invalid_am_thr),
                .i_valid_am_thr         (i_valid_am_thr),
                .o_data                 (o_data),
                .o_valid                (o_valid),
                .o_lane_id              (o_lane_id),
                .o_error_counter        (o_error_counter),
                .o_am_lock              (o_am_lock),
                .o_resync               (o_resync),
                .o_start_of_lane        (o_start_of_lane)
        );

        always #4 tb_clock = ~tb_clock;

        always @(posedge tb_clock)
                cycle <= cycle + 1;

        task automatic abort_run();
                begin
                        $display("Test FAILED");
                        $fatal(1);
                end
        endtask

        task automatic report_failure(input string what);
                begin
                        $display("ERROR at %0t: %s", $time, what);
                        abort_run();
                end
        endtask

        task automatic check_value(input logic [65:0] actual, input logic [65:0] expected,
                                   input string what);
                begin
                        if (actual !== expected)
                        begin
                                $display("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                                         $time, what, actual, expected);
                                abort_run();
                        end
                end
        endtask

        // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per bit taken
        function automatic logic random_bit();
                logic fb;
                fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                lfsr = {lfsr[30:0], fb};
                return fb;
        endfunction

        // Sync header 01 keeps filler data from ever looking like a marker
        function automatic am_lock_pkg::coded_block_t make_filler();
                am_lock_pkg::coded_block_t b;
                b[65:64] = 2'b01;
                for (int i = 0; i < 64; i++)
                        b[i] = random_bit();
                return b;
        endfunction

        // Marker is 10, M0 M1 M2, BIP3, inverted M0 M1 M2, BIP7 with random BIP bytes
        function automatic am_lock_pkg::coded_block_t make_marker(input int lane, input bit bad);
                am_lock_pkg::am_marker_t    m;
                logic [7:0]                 bip3;
                logic [7:0]                 bip7;
                am_lock_pkg::coded_block_t  b;
                m = am_lock_pkg::AM_TABLE[lane];
                for (int i = 0; i < 8; i++)
                begin
                        bip3[i] = random_bit();
                        bip7[i] = random_bit();
                end
                b = {2'b10, m, bip3, ~m, bip7};
                // One flipped bit in M1 leaves the block matching no lane at all
                if (bad)
                        b[50] = ~b[50];
                return b;
        endfunction

        // Checks every output block against the queue and keeps the marker status
        always @(negedge tb_clock)
        begin
                if (o_valid === 1'b1)
                begin
                        if (exp_data.size() == 0)
                                report_failure("o_valid went high with no accepted block pending");
                        check_value(o_data, exp_data.pop_front(), "o_data");
                        check_value(cycle - exp_cycle.pop_front(), 2, "o_data latency");
                        mon_tag = exp_tag.pop_front();
                        // Only a good marker of the expected lane may start the lane
                        if (mon_tag != expect_lane)
                                check_value(o_start_of_lane, 1'b0, "o_start_of_lane off a marker");
                        if (mon_tag != TAG_FILLER)
                        begin
                                snap_lock   = o_am_lock;
                                snap_sol    = o_start_of_lane;
                                snap_resync = o_resync;
                                snap_lane   = o_lane_id;
                                snap_err    = o_error_counter;
                        end
                end
                else
                begin
                        check_value(o_start_of_lane, 1'b0, "o_start_of_lane without o_valid");
                        check_value(o_resync, 1'b0, "o_resync without o_valid");
                end
                if (o_resync === 1'b1)
                        n_resync++;
                if (i_rst_n && i_valid && i_enable && i_block_lock)
                begin
                        exp_data.push_back(i_data);
                        exp_cycle.push_back(cycle);
                        exp_tag.push_back(drive_tag);
                end
        end

        task automatic send_block(input am_lock_pkg::coded_block_t data, input int tag);
                begin
                        @(posedge tb_clock);
                        #1;
                        i_valid   = 1'b1;
                        i_data    = data;
                        drive_tag = tag;
                end
        endtask

        // Stops the stream and waits until every accepted block has come out
        task automatic drain();
                int i;
                begin
                        @(posedge tb_clock);
                        #1;
                        i_valid = 1'b0;
                        for (i = 0; i < TIMEOUT && exp_data.size() != 0; i++)
                                @(posedge tb_clock);
                        if (exp_data.size() != 0)
                                report_failure("timeout waiting for accepted blocks on o_data");
                end
        endtask

        // One marker period with the marker or its corrupted copy first and fillers after it
        task automatic send_period(input int lane, input bit bad);
                begin
                        send_block(make_marker(lane, bad), bad ? TAG_BAD : lane);
                        for (int i = 1; i < am_lock_pkg::AM_PERIOD; i++)
                                send_block(make_filler(), TAG_FILLER);
                        drain();
                end
        endtask

        task automatic compare_marker_status(input logic lock, input logic sol,
                                             input logic resync);
                begin
                        check_value(snap_lock, lock, "o_am_lock at the marker slot");
                        check_value(snap_sol, sol, "o_start_of_lane at the marker slot");
                        check_value(snap_resync, resync, "o_resync at the marker slot");
                        check_value(snap_err, exp_err, "o_error_counter at the marker slot");
                        if (lock)
                                check_value(snap_lane, expect_lane, "o_lane_id");
                end
        endtask

        task automatic apply_reset();
                begin
                        @(posedge tb_clock);
                        #1;
                        i_rst_n = 1'b0;
                        i_valid = 1'b0;
                        repeat (10) @(posedge tb_clock);
                        #1;
                        i_rst_n = 1'b1;
                        exp_err = 0;
                end
        endtask

        task automatic passthrough_after_reset();
                int i;
                begin
                        @(negedge tb_clock);
                        check_value(o_valid, 1'b0, "o_valid after reset");
                        check_value(o_am_lock, 1'b0, "o_am_lock after reset");
                        check_value(o_resync, 1'b0, "o_resync after reset");
                        check_value(o_start_of_lane, 1'b0, "o_start_of_lane after reset");
                        check_value(o_error_counter, 0, "o_error_counter after reset");
                        for (i = 0; i < 5; i++)
                                send_block(make_filler(), TAG_FILLER);
                        drain();
                        // With the path disabled nothing may reach the output
                        @(posedge tb_clock);
                        #1;
                        i_enable = 1'b0;
                        for (i = 0; i < 5; i++)
                                send_block(make_filler(), TAG_FILLER);
                        drain();
                        for (i = 0; i < 4; i++)
                                @(negedge tb_clock);
                        @(posedge tb_clock);
                        #1;
                        i_enable = 1'b1;
                end
        endtask

        task automatic reject_wrong_lane();
                begin
                        expect_lane = 4;
                        send_period(4, 1'b0);
                        compare_marker_status(1'b0, 1'b0, 1'b0);
                        // Lane 7 arrives where the second lane 4 marker was due
                        send_period(7, 1'b0);
                        compare_marker_status(1'b0, 1'b0, 1'b0);
                        expect_lane = 7;
                        send_period(7, 1'b0);
                        compare_marker_status(1'b0, 1'b0, 1'b0);
                        send_period(7, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                end
        endtask

        task automatic acquire_lock();
                begin
                        expect_lane = 4;
                        send_period(4, 1'b0);
                        compare_marker_status(1'b0, 1'b0, 1'b0);
                        send_period(4, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                        send_period(4, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                end
        endtask

        task automatic recover_from_bad_marker();
                begin
                        send_period(4, 1'b1);
                        exp_err++;
                        compare_marker_status(1'b1, 1'b0, 1'b0);
                        send_period(4, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                        send_period(4, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                end
        endtask

        task automatic lose_lock();
                int start;
                begin
                        start = n_resync;
                        for (int k = 1; k <= 3; k++)
                        begin
                                send_period(4, 1'b1);
                                exp_err++;
                                compare_marker_status(k < 3, 1'b0, k == 3);
                        end
                        // A single good marker only starts a new check
                        send_period(4, 1'b0);
                        compare_marker_status(1'b0, 1'b0, 1'b0);
                        check_value(n_resync - start, 1, "o_resync pulse count");
                end
        endtask

        task automatic drop_block_lock();
                int start;
                int i;
                begin
                        send_period(4, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                        start = n_resync;
                        @(posedge tb_clock);
                        #1;
                        i_block_lock = 1'b0;
                        for (i = 0; i < TIMEOUT && o_am_lock; i++)
                                @(negedge tb_clock);
                        if (o_am_lock)
                                report_failure("o_am_lock stayed high after block lock was lost");
                        @(posedge tb_clock);
                        #1;
                        i_block_lock = 1'b1;
                        send_period(4, 1'b0);
                        compare_marker_status(1'b0, 1'b0, 1'b0);
                        send_period(4, 1'b0);
                        compare_marker_status(1'b1, 1'b1, 1'b0);
                        check_value(n_resync - start, 0, "o_resync on block lock loss");
                end
        endtask

        initial
        begin
                lfsr             = 32'hfda0_d35d;
                i_rst_n          = 1'b0;
                i_enable         = 1'b1;
                i_valid          = 1'b0;
                i_block_lock     = 1'b1;
                i_data           = '0;
                i_invalid_am_thr = 4'd3;
                i_valid_am_thr   = 5'd2;
                drive_tag        = TAG_FILLER;
                expect_lane      = 4;
                exp_err          = 0;
                apply_reset();
                passthrough_after_reset();
                reject_wrong_lane();
                apply_reset();
                acquire_lock();
                recover_from_bad_marker();
                lose_lock();
                drop_block_lock();
                $display("Test OK");
                $finish;
        end

endmodule

// File: verilog/am_block_counter.sv
`timescale 1ns/1ps

module am_block_counter
(
        input  logic                     tb_clock,
        input  logic                     i_rst_n,
        input  am_lock_pkg::match_info_t i_match,
        input  logic                     i_restart,
        output logic                     o_am_slot
);

        // Position of the next valid stage-one block within the marker period
        // While a valid block sits in stage one this is that block's position
        am_lock_pkg::am_count_t count;
        logic                   at_wrap;

        assign at_wrap = (count == am_lock_pkg::am_count_t'(am_lock_pkg::AM_PERIOD - 1));

        always_ff @(posedge tb_clock)
        begin
                if (!i_rst_n)
                begin
                        count <= '0;
                end
                else if (i_restart)
                begin
                        // The current block becomes position zero, so the next one is 1
                        count <= am_lock_pkg::am_count_t'(1);
                end
                else if (i_match.valid)
                begin
                        if (at_wrap)
                        begin
                                count <= '0;
                        end
                        else
                        begin
                                count <= count + 1'b1;
                        end
                end
        end

        // Position zero is where the next marker is expected
        assign o_am_slot = (count == '0);

endmodule

// File: verilog/am_lock_fsm.sv
`timescale 1ns/1ps

module am_lock_fsm
(
        input  logic                       tb_clock,
        input  logic                       i_rst_n,
        input  am_lock_pkg::match_info_t   i_match,
        input  logic                       i_am_slot,
        input  logic                       i_block_lock,
        input  am_lock_pkg::inv_am_thr_t   i_invalid_am_thr,
        input  am_lock_pkg::val_am_thr_t   i_valid_am_thr,
        output logic                       o_restart,
        output am_lock_pkg::coded_block_t  o_data,
        output logic                       o_valid,
        output am_lock_pkg::lane_id_t      o_lane_id,
        output am_lock_pkg::error_count_t  o_error_counter,
        output logic                       o_am_lock,
        output logic                       o_resync,
        output logic                       o_start_of_lane
);

        am_lock_pkg::lock_state_t   state;
        am_lock_pkg::lock_state_t   state_next;
        am_lock_pkg::lane_id_t      lane_q;
        am_lock_pkg::lane_id_t      lane_next;
        am_lock_pkg::val_am_thr_t   val_cnt;
        am_lock_pkg::val_am_thr_t   val_next;
        am_lock_pkg::inv_am_thr_t   inv_cnt;
        am_lock_pkg::inv_am_thr_t   inv_next;
        am_lock_pkg::error_count_t  err_cnt;
        am_lock_pkg::error_count_t  err_next;
        logic                       good_am;
        logic                       resync_next;
        logic                       start_next;

        // A marker of the lane captured during search
        assign good_am = i_match.is_am && (i_match.lane == lane_q);

        always_comb
        begin
                state_next  = state;
                lane_next   = lane_q;
                val_next    = val_cnt;
                inv_next    = inv_cnt;
                err_next    = err_cnt;
                resync_next = 1'b0;
                o_restart   = 1'b0;

                if (!i_block_lock)
                begin
                        // Losing block lock drops marker lock quietly, without a resync
                        state_next = am_lock_pkg::ST_SEARCH;
                end
                else if (i_match.valid)
                begin
                        case (state)
                        am_lock_pkg::ST_SEARCH:
                        begin
                                // Any marker starts a candidate alignment and realigns the counter
                                if (i_match.is_am)
                                begin
                                        lane_next  = i_match.lane;
                                        val_next   = am_lock_pkg::val_am_thr_t'(1);
                                        o_restart  = 1'b1;
                                        state_next = am_lock_pkg::ST_CHECK;
                                end
                        end
                        am_lock_pkg::ST_CHECK:
                        begin
                                if (i_am_slot)
                                begin
                                        if (good_am)
                                        begin
                                                val_next = val_cnt + 1'b1;
                                                if (val_next >= i_valid_am_thr)
                                                begin
                                                        inv_next   = '0;
                                                        state_next = am_lock_pkg::ST_LOCKED;
                                                end
                                        end
                                        else
                                        begin
                                                // Wrong lane or no marker where one was due
                                                state_next = am_lock_pkg::ST_SEARCH;
                                        end
                                end
                        end
                        am_lock_pkg::ST_LOCKED:
                        begin
                                if (i_am_slot)
                                begin
                                        if (good_am)
                                        begin
                                                inv_next = '0;
                                        end
                                        else
                                        begin
                                                inv_next = inv_cnt + 1'b1;
                                                // Error count sticks at full scale
                                                if (err_cnt != '1)
                                                begin
                                                        err_next = err_cnt + 1'b1;
                                                end
                                                if (inv_next >= i_invalid_am_thr)
                                                begin
                                                        resync_next = 1'b1;
                                                        state_next  = am_lock_pkg::ST_SEARCH;
                                                end
                                        end
                                end
                        end
                        default:
                        begin
                                state_next = am_lock_pkg::ST_SEARCH;
                        end
                        endcase
                end

                // Marks the lane's marker whenever lock holds after it, the locking one included
                start_next = i_match.valid && i_am_slot && good_am &&
                             (state_next == am_lock_pkg::ST_LOCKED);
        end

        always_ff @(posedge tb_clock)
        begin
                if (!i_rst_n)
                begin
                        state           <= am_lock_pkg::ST_SEARCH;
                        lane_q          <= '0;
                        val_cnt         <= '0;
                        inv_cnt         <= '0;
                        err_cnt         <= '0;
                        o_valid         <= 1'b0;
                        o_resync        <= 1'b0;
                        o_start_of_lane <= 1'b0;
                end
                else
                begin
                        state           <= state_next;
                        lane_q          <= lane_next;
                        val_cnt         <= val_next;
                        inv_cnt         <= inv_next;
                        err_cnt         <= err_next;
                        o_valid         <= i_match.valid;
                        o_resync        <= resync_next;
                        o_start_of_lane <= start_next;
                end
        end

        // Data leaves on the same edge as the status it caused
        always_ff @(posedge tb_clock)
        begin
                if (i_match.valid)
                begin
                        o_data <= i_match.block;
                end
        end

        assign o_am_lock       = (state == am_lock_pkg::ST_LOCKED);
        assign o_lane_id       = lane_q;
        assign o_error_counter = err_cnt;

endmodule

// File: verilog/am_lock_pkg.sv
package am_lock_pkg;

        // Coded block and lane geometry
        localparam int NB_CODED_BLOCK   = 66;
        localparam int N_LANES          = 20;
        localparam int NB_LANE_ID       = 5;

        // Blocks from one marker to the next, counting the marker itself
        // The standard value is 16384, kept small here for short runs
        localparam int AM_PERIOD        = 10;
        localparam int NB_AM_COUNT      = 14;

        // Widths of the run-time thresholds and of the error count
        localparam int NB_INV_AM        = 4;
        localparam int NB_VAL_AM        = 5;
        localparam int NB_ERROR_COUNTER = 16;

        // A marker block is sync, M0 M1 M2, BIP3, ~M0 ~M1 ~M2, BIP7 from the MSB down
        localparam int NB_AM_MARKER     = 24;
        localparam int AM_MARK_LSB      = 40;
        localparam int AM_INV_LSB       = 8;
        localparam logic [1:0] AM_SYNC_HEADER = 2'b10;

        typedef logic [NB_CODED_BLOCK-1:0]   coded_block_t;
        typedef logic [NB_LANE_ID-1:0]       lane_id_t;
        typedef logic [NB_AM_COUNT-1:0]      am_count_t;
        typedef logic [NB_INV_AM-1:0]        inv_am_thr_t;
        typedef logic [NB_VAL_AM-1:0]        val_am_thr_t;
        typedef logic [NB_ERROR_COUNTER-1:0] error_count_t;
        typedef logic [NB_AM_MARKER-1:0]     am_marker_t;

        // Marker bytes M0, M1, M2 of each physical lane, indexed by lane number
        localparam am_marker_t AM_TABLE [N_LANES] = '{
                24'hC16821, 24'h9D718E, 24'h594BE8, 24'h4D957B, 24'hF50709,
                24'hDD14C2, 24'h9A4A26, 24'h7B4566, 24'hA02476, 24'h68C9FB,
                24'hFD6C99, 24'hB99155, 24'h5CB9B2, 24'h1AF8BD, 24'h83C7CA,
                24'h3536CD, 24'hC4314C, 24'hADD6B7, 24'h5F662A, 24'hC0F0E5
        };

        // Result of the first stage, carried with the block it belongs to
        typedef struct packed {
                logic           valid;
                logic           is_am;
                lane_id_t       lane;
                coded_block_t   block;
        } match_info_t;

        typedef enum logic [1:0] {
                ST_SEARCH,
                ST_CHECK,
                ST_LOCKED
        } lock_state_t;

endpackage

// File: verilog/am_lock_top.sv
`timescale 1ns/1ps

module am_lock_top
(
        input  logic                       tb_clock,
        input  logic                       i_rst_n,
        input  logic                       i_enable,
        input  logic                       i_valid,
        input  logic                       i_block_lock,
        input  am_lock_pkg::coded_block_t  i_data,
        input  am_lock_pkg::inv_am_thr_t   i_invalid_am_thr,
        input  am_lock_pkg::val_am_thr_t   i_valid_am_thr,
        output am_lock_pkg::coded_block_t  o_data,
        output logic                       o_valid,
        output am_lock_pkg::lane_id_t      o_lane_id,
        output am_lock_pkg::error_count_t  o_error_counter,
        output logic                       o_am_lock,
        output logic                       o_resync,
        output logic                       o_start_of_lane
);

        // Stage-one result shared by the counter and the FSM
        am_lock_pkg::match_info_t match;
        logic                     am_slot;
        logic                     restart;

        am_pattern_matcher u_matcher
        (
                .tb_clock       (tb_clock),
                .i_rst_n        (i_rst_n),
                .i_enable       (i_enable),
                .i_valid        (i_valid),
                .i_block_lock   (i_block_lock),
                .i_data         (i_data),
                .o_match        (match)
        );

        // The FSM realigns the counter on the marker that starts a search hit
        am_block_counter u_counter
        (
                .tb_clock       (tb_clock),
                .i_rst_n        (i_rst_n),
                .i_match        (match),
                .i_restart      (restart),
                .o_am_slot      (am_slot)
        );

        am_lock_fsm u_fsm
        (
                .tb_clock               (tb_clock),
                .i_rst_n                (i_rst_n),
                .i_match                (match),
                .i_am_slot              (am_slot),
                .i_block_lock           (i_block_lock),
                .i_invalid_am_thr       (i_invalid_am_thr),
                .i_valid_am_thr         (i_valid_am_thr),
                .o_restart              (restart),
                .o_data                 (o_data),
                .o_valid                (o_valid),
                .o_lane_id              (o_lane_id),
                .o_error_counter        (o_error_counter),
                .o_am_lock              (o_am_lock),
                .o_resync               (o_resync),
                .o_start_of_lane        (o_start_of_lane)
        );

endmodule

// File: verilog/am_pattern_matcher.sv
`timescale 1ns/1ps

module am_pattern_matcher
(
        input  logic                      tb_clock,
        input  logic                      i_rst_n,
        input  logic                      i_enable,
        input  logic                      i_valid,
        input  logic                      i_block_lock,
        input  am_lock_pkg::coded_block_t i_data,
        output am_lock_pkg::match_info_t  o_match
);

        // A block is only taken in while the lane has block lock and the path is enabled
        logic                           accept;
        logic                           sync_ok;
        logic [am_lock_pkg::N_LANES-1:0] hit;
        am_lock_pkg::lane_id_t          hit_lane;

        // Stage registers
        logic                           valid_q;
        logic                           is_am_q;
        am_lock_pkg::lane_id_t          lane_q;
        am_lock_pkg::coded_block_t      block_q;

        assign accept = i_valid & i_enable & i_block_lock;

        // Compare against every lane's marker in parallel
        // The BIP bytes 3 and 7 carry parity and take no part in the match
        always_comb
        begin
                sync_ok = (i_data[am_lock_pkg::NB_CODED_BLOCK-1 -: 2] ==
                           am_lock_pkg::AM_SYNC_HEADER);
                for (int k = 0; k < am_lock_pkg::N_LANES; k++)
                begin
                        hit[k] = sync_ok &&
                                 (i_data[am_lock_pkg::AM_MARK_LSB +: am_lock_pkg::NB_AM_MARKER] ==
                                  am_lock_pkg::AM_TABLE[k]) &&
                                 (i_data[am_lock_pkg::AM_INV_LSB +: am_lock_pkg::NB_AM_MARKER] ==
                                  ~am_lock_pkg::AM_TABLE[k]);
                end
        end

        // The markers are all distinct, so at most one bit of hit is set
        always_comb
        begin
                hit_lane = '0;
                for (int k = 0; k < am_lock_pkg::N_LANES; k++)
                begin
                        if (hit[k])
                        begin
                                hit_lane = am_lock_pkg::lane_id_t'(k);
                        end
                end
        end

        always_ff @(posedge tb_clock)
        begin
                if (!i_rst_n)
                begin
                        valid_q <= 1'b0;
                end
                else
                begin
                        valid_q <= accept;
                end
        end

        // Payload only follows accepted blocks and is qualified by valid_q downstream
        always_ff @(posedge tb_clock)
        begin
                if (accept)
                begin
                        is_am_q <= |hit;
                        lane_q  <= hit_lane;
                        block_q <= i_data;
                end
        end

        assign o_match = '{valid: valid_q, is_am: is_am_q, lane: lane_q, block: block_q};

endmodule
